// File: frontend_top.f
isa_pkg.sv
bus_pkg.sv
decoder.sv
pc_gen.sv
inst_fetch.sv
inst_queue.sv
frontend_top.sv
tb_clock_gen.sv
frontend_properties.sv
tb_checker.sv
tb_frontend_top.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_frontend_top \
	-f frontend_top.f -o sim_frontend

./obj_dir/sim_frontend +verilator+error+limit+1000 | tee sim.log

if grep -qF 'All tests passed!' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: tb_frontend_top.sv
module tb_frontend_top
	import isa_pkg::*;
	import bus_pkg::*;
();

	localparam int fetch_size  = 2;
	localparam int queue_depth = 8;
	localparam int drive_delay = 1;
	localparam int num_deq     = 200;
	// idle, 4 address, 4 data, 1 to leave stage 2
	localparam int worst_inst_cycles = 10;
	localparam int hold_start        = 250;
	localparam int hold_end          = 400;
	localparam int timeout_cycles =
		4 * (num_deq * worst_inst_cycles + (hold_end - hold_start));
	localparam int redirect_a_cycle = 150;
	localparam int redirect_b_cycle = 380;
	localparam logic [31:0] redirect_a_pc = 32'h0000_0400;
	localparam logic [31:0] redirect_b_pc = 32'h0000_1204;
	localparam logic [31:0] lfsr_seed     = 32'hc4c2_9d3e;

	logic              clk;
	logic              rst_n;
	logic              redirect;
	logic [word_w-1:0] redirect_pc;
	logic              deq;
	logic              bus_ready;
	logic              bus_data_ok;
	logic [word_w-1:0] bus_rdata;
	logic              bus_req;
	logic [word_w-1:0] bus_addr;
	logic              bus_data_phase;
	logic              empty;
	logic [word_w-1:0] head_pc;
	op_e               head_op;
	logic [reg_w-1:0]  head_rs;
	logic [reg_w-1:0]  head_rt;
	logic [reg_w-1:0]  head_rd;
	logic [imm_w-1:0]  head_imm;
	logic [word_w-1:0] exp_pc;
	logic [word_w-1:0] exp_word;
	int                deq_count;
	int                err_count;
	int                cycle_cnt = 0;
	logic [31:0]       lfsr;
	logic              wait_armed;
	int                wait_left;
	logic [word_w-1:0] mem_addr;

	tb_clock_gen clock_gen_i (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	frontend_top #(
		.FETCH_SIZE  (fetch_size),
		.QUEUE_DEPTH (queue_depth)
	) frontend_top_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.redirect_i       (redirect),
		.redirect_pc_i    (redirect_pc),
		.deq_i            (deq),
		.bus_ready_i      (bus_ready),
		.bus_data_ok_i    (bus_data_ok),
		.bus_rdata_i      (bus_rdata),
		.bus_req_o        (bus_req),
		.bus_addr_o       (bus_addr),
		.bus_data_phase_o (bus_data_phase),
		.empty_o          (empty),
		.head_pc_o        (head_pc),
		.head_op_o        (head_op),
		.head_rs_o        (head_rs),
		.head_rt_o        (head_rt),
		.head_rd_o        (head_rd),
		.head_imm_o       (head_imm)
	);

	tb_checker checker_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.redirect_i    (redirect),
		.redirect_pc_i (redirect_pc),
		.deq_i         (deq),
		.empty_i       (empty),
		.head_pc_i     (head_pc),
		.head_op_i     (head_op),
		.head_rs_i     (head_rs),
		.head_rt_i     (head_rt),
		.head_rd_i     (head_rd),
		.head_imm_i    (head_imm),
		.exp_word_i    (exp_word),
		.exp_pc_o      (exp_pc),
		.deq_count_o   (deq_count),
		.err_count_o   (err_count)
	);

	// bus side of inst_fetch and empty flag of inst_queue, seen at the top level
	bind frontend_top frontend_properties props_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.bus_req_i        (bus_req_o),
		.bus_data_phase_i (bus_data_phase_o),
		.bus_ready_i      (bus_ready_i),
		.bus_addr_i       (bus_addr_o),
		.empty_i          (empty_o)
	);

	// galois form of x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ({1'b0, s[31:1]} ^ 32'h8020_0003) : {1'b0, s[31:1]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int k = 0; k < n; k++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// instruction built from address bits, every eighth word unsupported
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [29:0] idx;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		logic [15:0] imm;
		logic [31:0] w;
		int          kind;
		idx  = addr[31:2];
		rs   = idx[4:0] ^ idx[9:5];
		rt   = idx[9:5];
		rd   = idx[14:10] ^ idx[4:0];
		imm  = addr[15:0] ^ 16'h5a3c;
		kind = (int'(idx[2:0]) + int'(idx[6:3])) % 9;
		case (kind)
			0: w = {opc_special, rs, rt, rd, 5'd0, fn_addu};
			1: w = {opc_special, rs, rt, rd, 5'd0, fn_subu};
			2: w = {opc_special, rs, rt, rd, 5'd0, fn_and};
			3: w = {opc_special, rs, rt, rd, 5'd0, fn_or};
			4: w = {opc_addiu, rs, rt, imm};
			5: w = {opc_lw, rs, rt, imm};
			6: w = {opc_sw, rs, rt, imm};
			7: w = {opc_beq, rs, rt, imm};
			default: w = {opc_j, rs, rt, imm};
		endcase
		if (idx[2:0] == 3'd7) begin
			// bad opcode or bad function code
			w = idx[3] ? {6'h3f, rs, rt, imm} : {opc_special, rs, rt, rd, 5'd0, 6'h3f};
		end
		return w;
	endfunction

	assign exp_word = mem_word(exp_pc);

	// memory answers each phase after 0 to 3 wait cycles
	task automatic serve_bus();
		logic [31:0] r;
		bus_ready   = 1'b0;
		bus_data_ok = 1'b0;
		if (bus_req || bus_data_phase) begin
			if (!wait_armed) begin
				take_bits(2, r);
				wait_left  = int'(r);
				wait_armed = 1'b1;
			end
			if (wait_left != 0) begin
				wait_left--;
			end else begin
				wait_armed = 1'b0;
				if (bus_req) begin
					bus_ready = 1'b1;
					mem_addr  = bus_addr;
				end else begin
					bus_data_ok = 1'b1;
					bus_rdata   = mem_word(mem_addr);
				end
			end
		end
	endtask

	task automatic drive_consumer();
		logic [31:0] r;
		redirect = 1'b0;
		take_bits(1, r);
		// consumer stops for a while so the queue fills up
		deq = r[0] && !(cycle_cnt >= hold_start && cycle_cnt < hold_end);
		if (cycle_cnt == redirect_a_cycle) begin
			redirect    = 1'b1;
			redirect_pc = redirect_a_pc;
		end
		if (cycle_cnt == redirect_b_cycle) begin
			redirect    = 1'b1;
			redirect_pc = redirect_b_pc;
		end
	endtask

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	initial begin
		redirect    = 1'b0;
		redirect_pc = '0;
		deq         = 1'b0;
		bus_ready   = 1'b0;
		bus_data_ok = 1'b0;
		bus_rdata   = '0;
		lfsr        = lfsr_seed;
		wait_armed  = 1'b0;
		wait_left   = 0;
		mem_addr    = '0;
		forever begin
			@(posedge clk);
			#drive_delay;
			serve_bus();
			drive_consumer();
		end
	end

	initial begin : finish_run
		int   assert_fails;
		logic timed_out;
		wait (rst_n === 1'b1);
		while (deq_count < num_deq && cycle_cnt < timeout_cycles) begin
			@(posedge clk);
		end
		timed_out    = (deq_count < num_deq);
		assert_fails = frontend_top_i.props_i.fail_count;
		if (timed_out) begin
			$display("timeout: only %0d of %0d instructions dequeued after %0d cycles",
				deq_count, num_deq, cycle_cnt);
		end
		$display("%0d checker errors, %0d assertion failures, %0d instructions checked",
			err_count, assert_fails, deq_count);
		if (!timed_out && err_count == 0 && assert_fails == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// File: tb_checker.sv
module tb_checker
	import isa_pkg::*;
	import bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              redirect_i,
	input  logic [word_w-1:0] redirect_pc_i,
	input  logic              deq_i,
	input  logic              empty_i,
	input  logic [word_w-1:0] head_pc_i,
	input  op_e               head_op_i,
	input  logic [reg_w-1:0]  head_rs_i,
	input  logic [reg_w-1:0]  head_rt_i,
	input  logic [reg_w-1:0]  head_rd_i,
	input  logic [imm_w-1:0]  head_imm_i,
	input  logic [word_w-1:0] exp_word_i,
	output logic [word_w-1:0] exp_pc_o,
	output int                deq_count_o,
	output int                err_count_o
);

	// MIPS encodings of the supported subset
	function automatic op_e ref_op(input logic [31:0] w);
		op_e op;
		op = INVALID;
		if (w[31:26] == 6'h00) begin
			if (w[5:0] == 6'h21) op = ADDU;
			if (w[5:0] == 6'h23) op = SUBU;
			if (w[5:0] == 6'h24) op = AND;
			if (w[5:0] == 6'h25) op = OR;
		end
		if (w[31:26] == 6'h09) op = ADDIU;
		if (w[31:26] == 6'h23) op = LW;
		if (w[31:26] == 6'h2b) op = SW;
		if (w[31:26] == 6'h04) op = BEQ;
		if (w[31:26] == 6'h02) op = J;
		return op;
	endfunction

	// rs, rt, rd, then the low 16 bits
	function automatic logic [30:0] ref_fields(input logic [31:0] w);
		return {w[25:21], w[20:16], w[15:11], w[15:0]};
	endfunction

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			err_count_o = err_count_o + 1;
		end
	endtask

	// inputs settle after the rising edge, so look at them on the falling one
	always @(negedge clk) begin : compare
		logic [30:0] fields;
		if (!rst_n) begin
			exp_pc_o    = '0;
			deq_count_o = 0;
			err_count_o = 0;
		end else if (redirect_i) begin
			// queue is flushed, next entry starts at the target
			exp_pc_o = redirect_pc_i;
		end else if (deq_i && !empty_i) begin
			fields = ref_fields(exp_word_i);
			check_value("pc", head_pc_i, exp_pc_o);
			check_value("op", 32'(head_op_i), 32'(ref_op(exp_word_i)));
			check_value("rs", 32'(head_rs_i), 32'(fields[30:26]));
			check_value("rt", 32'(head_rt_i), 32'(fields[25:21]));
			check_value("rd", 32'(head_rd_i), 32'(fields[20:16]));
			check_value("imm", 32'(head_imm_i), 32'(fields[15:0]));
			deq_count_o = deq_count_o + 1;
			exp_pc_o    = exp_pc_o + 32'd4;
		end
	end

endmodule

// File: frontend_properties.sv
module frontend_properties
	import bus_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              bus_req_i,
	input  logic              bus_data_phase_i,
	input  logic              bus_ready_i,
	input  logic [word_w-1:0] bus_addr_i,
	input  logic              empty_i
);

	int fail_count = 0;

	// address held until the memory takes it
	addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_req_i && !bus_ready_i) |=> $stable(bus_addr_i))
		else begin
			$error("bus address changed while the request waited for ready");
			fail_count++;
		end

	no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
		!(bus_req_i && bus_data_phase_i))
		else begin
			$error("bus request and data phase were high together");
			fail_count++;
		end

	empty_after_reset: assert property (@(posedge clk) !rst_n |=> empty_i)
		else begin
			$error("queue not empty after reset");
			fail_count++;
		end

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int half_period  = 10;
	localparam int reset_cycles = 5;

	initial begin
		clk_o = 1'b0;
		forever #half_period clk_o = ~clk_o;
	end

	// release a little after the last reset edge
	initial begin
		rst_n_o = 1'b0;
		repeat (reset_cycles) @(posedge clk_o);
		#1;
		rst_n_o = 1'b1;
	end

endmodule

// File: frontend_top.sv
module frontend_top
	import isa_pkg::*;
	import bus_pkg::*;
#(
	parameter int FETCH_SIZE  = 2,
	parameter int QUEUE_DEPTH = 8
)(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              redirect_i,
	input  logic [word_w-1:0] redirect_pc_i,
	input  logic              deq_i,
	input  logic              bus_ready_i,
	input  logic              bus_data_ok_i,
	input  logic [word_w-1:0] bus_rdata_i,
	output logic              bus_req_o,
	output logic [word_w-1:0] bus_addr_o,
	output logic              bus_data_phase_o,
	output logic              empty_o,
	output logic [word_w-1:0] head_pc_o,
	output op_e               head_op_o,
	output logic [reg_w-1:0]  head_rs_o,
	output logic [reg_w-1:0]  head_rt_o,
	output logic [reg_w-1:0]  head_rd_o,
	output logic [imm_w-1:0]  head_imm_o
);

	logic [word_w-1:0]     group_pc;
	logic [FETCH_SIZE-1:0] group_valid;
	logic                  fetch_stall;
	logic                  fetch_busy;
	logic                  queue_stall;
	logic [word_w-1:0]     grp_pc;
	logic [FETCH_SIZE-1:0] grp_valid;
	op_e                   grp_op  [FETCH_SIZE];
	logic [reg_w-1:0]      grp_rs  [FETCH_SIZE];
	logic [reg_w-1:0]      grp_rt  [FETCH_SIZE];
	logic [reg_w-1:0]      grp_rd  [FETCH_SIZE];
	logic [imm_w-1:0]      grp_imm [FETCH_SIZE];

	// pc only moves when the fetch pipeline moves
	assign fetch_stall = fetch_busy | queue_stall;

	pc_gen #(
		.FETCH_SIZE (FETCH_SIZE)
	) pc_gen_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.stall_i       (fetch_stall),
		.redirect_i    (redirect_i),
		.redirect_pc_i (redirect_pc_i),
		.pc_o          (group_pc),
		.valid_o       (group_valid)
	);

	inst_fetch #(
		.FETCH_SIZE (FETCH_SIZE)
	) inst_fetch_i (
		.clk              (clk),
		.rst_n            (rst_n),
		.pc_i             (group_pc),
		.valid_i          (group_valid),
		.stall_i          (queue_stall),
		.clr_i            (redirect_i),
		.busy_o           (fetch_busy),
		.bus_req_o        (bus_req_o),
		.bus_data_phase_o (bus_data_phase_o),
		.bus_addr_o       (bus_addr_o),
		.bus_ready_i      (bus_ready_i),
		.bus_data_ok_i    (bus_data_ok_i),
		.bus_rdata_i      (bus_rdata_i),
		.pc_o             (grp_pc),
		.valid_o          (grp_valid),
		.op_o             (grp_op),
		.rs_o             (grp_rs),
		.rt_o             (grp_rt),
		.rd_o             (grp_rd),
		.imm_o            (grp_imm)
	);

	inst_queue #(
		.FETCH_SIZE  (FETCH_SIZE),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) inst_queue_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.flush_i     (redirect_i),
		.grp_pc_i    (grp_pc),
		.grp_valid_i (grp_valid),
		.grp_op_i    (grp_op),
		.grp_rs_i    (grp_rs),
		.grp_rt_i    (grp_rt),
		.grp_rd_i    (grp_rd),
		.grp_imm_i   (grp_imm),
		.deq_i       (deq_i),
		.stall_o     (queue_stall),
		.empty_o     (empty_o),
		.head_pc_o   (head_pc_o),
		.head_op_o   (head_op_o),
		.head_rs_o   (head_rs_o),
		.head_rt_o   (head_rt_o),
		.head_rd_o   (head_rd_o),
		.head_imm_o  (head_imm_o)
	);

endmodule

// File: inst_queue.sv
module inst_queue
	import isa_pkg::*;
	import bus_pkg::*;
#(
	parameter int FETCH_SIZE  = 2,
	parameter int QUEUE_DEPTH = 8
)(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  flush_i,
	input  logic [word_w-1:0]     grp_pc_i,
	input  logic [FETCH_SIZE-1:0] grp_valid_i,
	input  op_e                   grp_op_i [FETCH_SIZE],
	input  logic [reg_w-1:0]      grp_rs_i [FETCH_SIZE],
	input  logic [reg_w-1:0]      grp_rt_i [FETCH_SIZE],
	input  logic [reg_w-1:0]      grp_rd_i [FETCH_SIZE],
	input  logic [imm_w-1:0]      grp_imm_i [FETCH_SIZE],
	input  logic                  deq_i,
	output logic                  stall_o,
	output logic                  empty_o,
	output logic [word_w-1:0]     head_pc_o,
	output op_e                   head_op_o,
	output logic [reg_w-1:0]      head_rs_o,
	output logic [reg_w-1:0]      head_rt_o,
	output logic [reg_w-1:0]      head_rd_o,
	output logic [imm_w-1:0]      head_imm_o
);

	localparam int ptr_w = $clog2(QUEUE_DEPTH);

	logic [word_w-1:0] pc_mem  [QUEUE_DEPTH];
	op_e               op_mem  [QUEUE_DEPTH];
	logic [reg_w-1:0]  rs_mem  [QUEUE_DEPTH];
	logic [reg_w-1:0]  rt_mem  [QUEUE_DEPTH];
	logic [reg_w-1:0]  rd_mem  [QUEUE_DEPTH];
	logic [imm_w-1:0]  imm_mem [QUEUE_DEPTH];

	logic [ptr_w-1:0]  wr_ptr;
	logic [ptr_w-1:0]  rd_ptr;
	logic [ptr_w:0]    count;
	logic [ptr_w-1:0]  wr_idx [FETCH_SIZE];
	logic [ptr_w:0]    enq_cnt;
	logic [ptr_w:0]    add_cnt;
	logic              enq;
	logic              deq;

	assign enq     = ~stall_o & ~flush_i;
	assign deq     = deq_i & ~empty_o & ~flush_i;
	assign add_cnt = enq ? enq_cnt : '0;

	// pack valid slots onto consecutive entries
	always_comb begin
		enq_cnt = '0;
		for (int i = 0; i < FETCH_SIZE; i++) begin
			wr_idx[i] = wr_ptr + enq_cnt[ptr_w-1:0];
			if (grp_valid_i[i]) begin
				enq_cnt = enq_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (enq) begin
			for (int i = 0; i < FETCH_SIZE; i++) begin
				if (grp_valid_i[i]) begin
					pc_mem[wr_idx[i]]  <= grp_pc_i + (word_w'(i) << 2);
					op_mem[wr_idx[i]]  <= grp_op_i[i];
					rs_mem[wr_idx[i]]  <= grp_rs_i[i];
					rt_mem[wr_idx[i]]  <= grp_rt_i[i];
					rd_mem[wr_idx[i]]  <= grp_rd_i[i];
					imm_mem[wr_idx[i]] <= grp_imm_i[i];
				end
			end
		end
	end

	// pointers and fill level
	always_ff @(posedge clk) begin
		if (!rst_n || flush_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + add_cnt[ptr_w-1:0];
			rd_ptr <= rd_ptr + ptr_w'(deq);
			count  <= count + add_cnt - (ptr_w + 1)'(deq);
		end
	end

	// a whole group may not fit any more
	assign stall_o = (count > (ptr_w + 1)'(QUEUE_DEPTH - FETCH_SIZE));
	assign empty_o = (count == '0);

	assign head_pc_o  = pc_mem[rd_ptr];
	assign head_op_o  = op_mem[rd_ptr];
	assign head_rs_o  = rs_mem[rd_ptr];
	assign head_rt_o  = rt_mem[rd_ptr];
	assign head_rd_o  = rd_mem[rd_ptr];
	assign head_imm_o = imm_mem[rd_ptr];

endmodule

// File: inst_fetch.sv
module inst_fetch
	import isa_pkg::*;
	import bus_pkg::*;
#(
	parameter int FETCH_SIZE = 2
)(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [word_w-1:0]     pc_i,
	input  logic [FETCH_SIZE-1:0] valid_i,
	input  logic                  stall_i,
	input  logic                  clr_i,
	output logic                  busy_o,
	output logic                  bus_req_o,
	output logic                  bus_data_phase_o,
	output logic [word_w-1:0]     bus_addr_o,
	input  logic                  bus_ready_i,
	input  logic                  bus_data_ok_i,
	input  logic [word_w-1:0]     bus_rdata_i,
	output logic [word_w-1:0]     pc_o,
	output logic [FETCH_SIZE-1:0] valid_o,
	output op_e                   op_o [FETCH_SIZE],
	output logic [reg_w-1:0]      rs_o [FETCH_SIZE],
	output logic [reg_w-1:0]      rt_o [FETCH_SIZE],
	output logic [reg_w-1:0]      rd_o [FETCH_SIZE],
	output logic [imm_w-1:0]      imm_o [FETCH_SIZE]
);

	localparam int off_w = $clog2(FETCH_SIZE);

	logic [word_w-1:0]     pc_s1;
	logic [word_w-1:0]     pc_s2;
	logic [FETCH_SIZE-1:0] valid_s1;
	logic [FETCH_SIZE-1:0] valid_s2;
	logic [FETCH_SIZE-1:0] pending;
	logic [FETCH_SIZE-1:0] slot_mask;
	logic [off_w-1:0]      next_slot;
	logic [off_w-1:0]      slot_q;
	logic [word_w-1:0]     addr_q;
	bus_state_e            state;
	bus_state_e            state_nxt;
	logic                  stall_pipe;
	logic                  in_flight;
	logic                  xfer_done;
	op_e                   dec_op;
	logic [reg_w-1:0]      dec_rs;
	logic [reg_w-1:0]      dec_rt;
	logic [reg_w-1:0]      dec_rd;
	logic [imm_w-1:0]      dec_imm;

	assign busy_o     = |pending;
	assign stall_pipe = stall_i | busy_o;
	assign in_flight  = (state != IDLE);
	assign xfer_done  = (state == DATA) & bus_data_ok_i;
	assign slot_mask  = {{(FETCH_SIZE - 1){1'b0}}, 1'b1} << slot_q;

	// stage valids, cleared on redirect
	always_ff @(posedge clk) begin
		if (!rst_n || clr_i) begin
			valid_s1 <= '0;
			valid_s2 <= '0;
		end else if (!stall_pipe) begin
			valid_s1 <= valid_i;
			valid_s2 <= valid_s1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall_pipe) begin
			pc_s1 <= pc_i;
			pc_s2 <= pc_s1;
		end
	end

	// slots of stage 2 still waiting for their word
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pending <= '0;
		end else if (clr_i) begin
			// keep only the word already on the bus
			pending <= (in_flight && !xfer_done) ? slot_mask : '0;
		end else if (!stall_pipe) begin
			pending <= valid_s1;
		end else if (xfer_done) begin
			pending[slot_q] <= 1'b0;
		end
	end

	// lowest pending slot
	always_comb begin
		next_slot = '0;
		for (int i = FETCH_SIZE - 1; i >= 0; i--) begin
			if (pending[i]) begin
				next_slot = off_w'(i);
			end
		end
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE:    if (busy_o && !clr_i) state_nxt = ADDR;
			ADDR:    if (bus_ready_i) state_nxt = DATA;
			DATA:    if (bus_data_ok_i) state_nxt = IDLE;
			default: state_nxt = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// address and slot are frozen for the whole transaction
	always_ff @(posedge clk) begin
		if (state == IDLE) begin
			addr_q <= {pc_s2[word_w-1:off_w+2], next_slot, 2'b00};
			slot_q <= next_slot;
		end
	end

	assign bus_req_o        = (state == ADDR);
	assign bus_data_phase_o = (state == DATA);
	assign bus_addr_o       = addr_q;

	decoder decoder_i (
		.inst_i (bus_rdata_i),
		.op_o   (dec_op),
		.rs_o   (dec_rs),
		.rt_o   (dec_rt),
		.rd_o   (dec_rd),
		.imm_o  (dec_imm)
	);

	// per-slot decode results
	always_ff @(posedge clk) begin
		if (xfer_done) begin
			op_o[slot_q]  <= dec_op;
			rs_o[slot_q]  <= dec_rs;
			rt_o[slot_q]  <= dec_rt;
			rd_o[slot_q]  <= dec_rd;
			imm_o[slot_q] <= dec_imm;
		end
	end

	// group is done once nothing is pending
	assign valid_o = valid_s2 & {FETCH_SIZE{~busy_o}};
	assign pc_o    = pc_s2;

endmodule

// File: pc_gen.sv
module pc_gen
	import bus_pkg::*;
#(
	parameter int FETCH_SIZE = 2
)(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  stall_i,
	input  logic                  redirect_i,
	input  logic [word_w-1:0]     redirect_pc_i,
	output logic [word_w-1:0]     pc_o,
	output logic [FETCH_SIZE-1:0] valid_o
);

	localparam int off_w = $clog2(FETCH_SIZE);

	logic [word_w-1:0] pc_q;
	logic [off_w-1:0]  word_offs;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc_q <= '0;
		end else if (redirect_i) begin
			pc_q <= redirect_pc_i;
		end else if (!stall_i) begin
			// step to the next group boundary
			pc_q <= {pc_q[word_w-1:off_w+2] + 1'b1, {(off_w + 2){1'b0}}};
		end
	end

	assign word_offs = pc_q[off_w+1:2];

	// group pc is always aligned
	assign pc_o = {pc_q[word_w-1:off_w+2], {(off_w + 2){1'b0}}};

	// drop slots below the word offset after a mid-group redirect
	always_comb begin
		for (int i = 0; i < FETCH_SIZE; i++) begin
			valid_o[i] = (off_w'(i) >= word_offs);
		end
	end

endmodule

// File: decoder.sv
module decoder
	import isa_pkg::*;
(
	input  logic [31:0]      inst_i,
	output op_e              op_o,
	output logic [reg_w-1:0] rs_o,
	output logic [reg_w-1:0] rt_o,
	output logic [reg_w-1:0] rd_o,
	output logic [imm_w-1:0] imm_o
);

	logic [opc_w-1:0] opcode;
	logic [opc_w-1:0] funct;

	assign opcode = inst_i[31:26];
	assign funct  = inst_i[5:0];

	always_comb begin
		case (opcode)
			opc_special: begin
				// register type, funct picks the operation
				case (funct)
					fn_addu: op_o = ADDU;
					fn_subu: op_o = SUBU;
					fn_and:  op_o = AND;
					fn_or:   op_o = OR;
					default: op_o = INVALID;
				endcase
			end
			opc_addiu: begin
				op_o = ADDIU;
			end
			opc_lw: begin
				op_o = LW;
			end
			opc_sw: begin
				op_o = SW;
			end
			opc_beq: begin
				op_o = BEQ;
			end
			opc_j: begin
				op_o = J;
			end
			default: begin
				op_o = INVALID;
			end
		endcase
	end

	// fixed field positions
	assign rs_o = inst_i[25:21];
	assign rt_o = inst_i[20:16];
	assign rd_o = inst_i[15:11];

	// immediate, or the low target bits for J
	assign imm_o = inst_i[imm_w-1:0];

endmodule

// File: bus_pkg.sv
package bus_pkg;

	// data and address width of the read bus
	localparam int word_w = 32;

	// one transaction: address phase, then data phase
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		ADDR = 2'd1,
		DATA = 2'd2
	} bus_state_e;

endpackage

// File: isa_pkg.sv
package isa_pkg;

	// register index and immediate field widths
	localparam int reg_w = 5;
	localparam int imm_w = 16;
	localparam int opc_w = 6;

	// decoded operation, INVALID for anything outside the subset
	typedef enum logic [3:0] {
		ADDU    = 4'd0,
		SUBU    = 4'd1,
		AND     = 4'd2,
		OR      = 4'd3,
		ADDIU   = 4'd4,
		LW      = 4'd5,
		SW      = 4'd6,
		BEQ     = 4'd7,
		J       = 4'd8,
		INVALID = 4'd15
	} op_e;

	// primary opcodes
	localparam logic [opc_w-1:0] opc_special = 6'h00;
	localparam logic [opc_w-1:0] opc_j       = 6'h02;
	localparam logic [opc_w-1:0] opc_beq     = 6'h04;
	localparam logic [opc_w-1:0] opc_addiu   = 6'h09;
	localparam logic [opc_w-1:0] opc_lw      = 6'h23;
	localparam logic [opc_w-1:0] opc_sw      = 6'h2b;

	// function codes of the register-type group
	localparam logic [opc_w-1:0] fn_addu = 6'h21;
	localparam logic [opc_w-1:0] fn_subu = 6'h23;
	localparam logic [opc_w-1:0] fn_and  = 6'h24;
	localparam logic [opc_w-1:0] fn_or   = 6'h25;

endpackage
